//--- all.f
+incdir+.
rap_pkg.sv
ras_if.sv
distram_1rport_1wport.sv
ras.sv
ckpt_table.sv
ckpt_tag_counter.sv
ras_ctrl.sv
rap_top.sv
rap_props.sv
rap_tb.sv

//--- run.sh
#!/bin/sh
# build and run the RAS predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rap_tb -f all.f

out=$(./obj_dir/Vrap_tb)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

//--- rap_tb.sv
`timescale 1ns/1ps
`include "rap_cfg.svh"

module rap_tb;
    import rap_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic      CLK;
    logic      nRST;
    logic      pred_valid;
    logic      pred_is_call;
    logic      pred_is_ret;
    pc38_t     pred_link_pc38;
    logic      flush_valid;
    ckpt_tag_t flush_tag;
    pc38_t     pred_target_pc38;
    logic      pred_fallback;
    ckpt_tag_t pred_tag;
    logic      busy;

    // reference stack, newest entry at the back
    pc38_t     model[$];
    ckpt_tag_t exp_tag;
    integer    seed;
    string     cur_test;
    int        check_count;
    int        error_count;

    rap_top u_dut (
        .CLK              (CLK),
        .nRST             (nRST),
        .pred_valid       (pred_valid),
        .pred_is_call     (pred_is_call),
        .pred_is_ret      (pred_is_ret),
        .pred_link_pc38   (pred_link_pc38),
        .flush_valid      (flush_valid),
        .flush_tag        (flush_tag),
        .pred_target_pc38 (pred_target_pc38),
        .pred_fallback    (pred_fallback),
        .pred_tag         (pred_tag),
        .busy             (busy)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // --------------------------------------------------
    // compare tasks
    task automatic check_pc(input string what, input pc38_t exp, input pc38_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s %s: expected %h, got %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_cnt(input string what, input ras_cnt_t exp, input ras_cnt_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s %s: expected %0d, got %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s %s: expected %b, got %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_tag(input string what, input ckpt_tag_t exp, input ckpt_tag_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s %s: expected %0d, got %0d", cur_test, what, exp, act);
        end
    endtask

    // --------------------------------------------------
    // driving and model
    function automatic pc38_t next_link_pc();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[`RAP_PC_WIDTH-1:0];
    endfunction

    // drive 1 ns after the edge, return mid-cycle with outputs settled
    task automatic apply(input logic v, input logic c, input logic r, input pc38_t pc,
                         input logic f, input ckpt_tag_t ft);
        @(posedge CLK);
        #1;
        pred_valid     = v;
        pred_is_call   = c;
        pred_is_ret    = r;
        pred_link_pc38 = pc;
        flush_valid    = f;
        flush_tag      = ft;
        #4;
    endtask

    task automatic apply_idle();
        apply(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic check_top();
        check_bit("fallback", model.size() == 0, pred_fallback);
        check_cnt("count", ras_cnt_t'(model.size()), u_dut.u_ras.count);
        if (model.size() > 0) begin
            check_pc("target", model[model.size()-1], pred_target_pc38);
        end
    endtask

    task automatic check_state();
        check_top();
        check_tag("pred_tag", exp_tag, pred_tag);
        check_bit("busy", 1'b0, busy);
    endtask

    // one accepted prediction: check the outputs it sees, then update the model
    task automatic do_pred(input logic call, input logic ret, input pc38_t pc);
        apply(1'b1, call, ret, pc, 1'b0, '0);
        check_state();
        if (call && ret && model.size() > 0) begin
            model[model.size()-1] = pc;
        end
        else if (call) begin
            model.push_back(pc);
            if (model.size() > `RAP_RAS_ENTRIES) begin
                void'(model.pop_front());
            end
        end
        else if (ret && model.size() > 0) begin
            void'(model.pop_back());
        end
        exp_tag = ckpt_tag_t'(exp_tag + 1);
    endtask

    // --------------------------------------------------
    // tests
    task automatic test_reset_state();
        cur_test = "reset_state";
        apply_idle();
        check_state();
        // return on an empty stack must not pop
        do_pred(1'b0, 1'b1, '0);
        apply_idle();
        check_state();
    endtask

    task automatic test_call_return();
        cur_test = "call_return";
        repeat (3) do_pred(1'b1, 1'b0, next_link_pc());
        repeat (3) do_pred(1'b0, 1'b1, '0);
        apply_idle();
        check_state();
    endtask

    task automatic test_overflow();
        cur_test = "overflow";
        repeat (10) do_pred(1'b1, 1'b0, next_link_pc());
        repeat (`RAP_RAS_ENTRIES) do_pred(1'b0, 1'b1, '0);
        apply_idle();
        check_state();
    endtask

    task automatic test_call_and_return();
        cur_test = "call_and_return";
        do_pred(1'b1, 1'b1, next_link_pc());
        do_pred(1'b1, 1'b1, next_link_pc());
        do_pred(1'b0, 1'b1, '0);
        apply_idle();
        check_state();
    endtask

    task automatic test_flush();
        ckpt_tag_t flushed_tag;
        int        saved_size;
        pc38_t     second_pc;
        cur_test = "flush";
        do_pred(1'b1, 1'b0, next_link_pc());
        second_pc = next_link_pc();
        do_pred(1'b1, 1'b0, second_pc);
        flushed_tag = exp_tag;
        saved_size  = model.size();
        repeat (3) do_pred(1'b1, 1'b0, next_link_pc());

        // calls offered during the two busy cycles are dropped
        apply(1'b1, 1'b1, 1'b0, next_link_pc(), 1'b1, flushed_tag);
        check_bit("busy in flush cycle", 1'b1, busy);
        apply(1'b1, 1'b1, 1'b0, next_link_pc(), 1'b0, '0);
        check_bit("busy in restore cycle", 1'b1, busy);
        apply_idle();

        while (model.size() > saved_size) begin
            void'(model.pop_back());
        end
        exp_tag = ckpt_tag_t'(flushed_tag + 1);
        check_pc("restored target", second_pc, pred_target_pc38);
        check_state();
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        seed           = 3;
        check_count    = 0;
        error_count    = 0;
        exp_tag        = '0;
        cur_test       = "init";
        nRST           = 1'b0;
        pred_valid     = 1'b0;
        pred_is_call   = 1'b0;
        pred_is_ret    = 1'b0;
        pred_link_pc38 = '0;
        flush_valid    = 1'b0;
        flush_tag      = '0;
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;

        test_reset_state();
        test_call_return();
        test_overflow();
        test_call_and_return();
        test_flush();

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, u_dut.u_ctrl.u_props.fail_count);
        if (error_count == 0 && u_dut.u_ctrl.u_props.fail_count == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 5) @(posedge CLK);
        $display("timeout: tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- rap_props.sv
`timescale 1ns/1ps

module rap_props (
    input logic                 CLK,
    input logic                 nRST,
    input rap_pkg::ctrl_state_t state,
    input logic                 busy,
    input logic                 flush_valid,
    input logic                 link_valid,
    input logic                 update_valid
);
    import rap_pkg::*;

    // failed assertion count
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // --------------------------------------------------
    // restore sequencing

    // update only in the cycle right after a flush taken in ST_RUN
    a_update_in_restore: assert property (@(posedge CLK) disable iff (!nRST)
        update_valid |-> $past(flush_valid && state == ST_RUN))
        else begin
            $error("update_valid high outside ST_RESTORE");
            fail_count++;
        end

    a_restore_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        state == ST_RESTORE |=> state == ST_RUN)
        else begin
            $error("ST_RESTORE held for more than one cycle");
            fail_count++;
        end

    // a push must never race a pointer restore
    a_no_link_on_update: assert property (@(posedge CLK) disable iff (!nRST)
        !(link_valid && update_valid))
        else begin
            $error("link_valid and update_valid high together");
            fail_count++;
        end

    a_idle_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(nRST) |-> !busy)
        else begin
            $error("busy high right after reset");
            fail_count++;
        end

endmodule

bind ras_ctrl rap_props u_props (
    .CLK          (CLK),
    .nRST         (nRST),
    .state        (state),
    .busy         (busy),
    .flush_valid  (flush_valid),
    .link_valid   (rif.link_valid),
    .update_valid (rif.update_valid)
);

//--- rap_top.sv
`timescale 1ns/1ps

module rap_top (
    input  logic               CLK,
    input  logic               nRST,

    // prediction request
    input  logic               pred_valid,
    input  logic               pred_is_call,
    input  logic               pred_is_ret,
    input  rap_pkg::pc38_t     pred_link_pc38,

    // flush back to a checkpoint
    input  logic               flush_valid,
    input  rap_pkg::ckpt_tag_t flush_tag,

    // prediction result
    output rap_pkg::pc38_t     pred_target_pc38,
    output logic               pred_fallback,
    output rap_pkg::ckpt_tag_t pred_tag,
    output logic               busy
);

    logic accept;

    ras_if rif ();

    // --------------------------------------------------
    // control and stack
    ras_ctrl u_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .rif            (rif.ctrl),
        .pred_valid     (pred_valid),
        .pred_is_call   (pred_is_call),
        .pred_is_ret    (pred_is_ret),
        .pred_link_pc38 (pred_link_pc38),
        .flush_valid    (flush_valid),
        .accept         (accept),
        .busy           (busy)
    );

    ras u_ras (
        .CLK  (CLK),
        .nRST (nRST),
        .rif  (rif.stack)
    );

    // --------------------------------------------------
    // checkpointing
    ckpt_table u_ckpt_table (
        .CLK         (CLK),
        .nRST        (nRST),
        .rif         (rif.snap),
        .snap_en     (accept),
        .snap_tag    (pred_tag),
        .restore_en  (flush_valid),
        .restore_tag (flush_tag)
    );

    // each accepted prediction is tagged with the current count
    ckpt_tag_counter u_tag_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .advance    (accept),
        .rewind     (flush_valid),
        .rewind_tag (flush_tag),
        .tag        (pred_tag)
    );

    assign pred_target_pc38 = rif.ret_pc38;
    assign pred_fallback    = rif.ret_fallback;

endmodule

//--- ras_ctrl.sv
`timescale 1ns/1ps

module ras_ctrl (
    input  logic           CLK,
    input  logic           nRST,
    ras_if.ctrl            rif,

    // fetch side
    input  logic           pred_valid,
    input  logic           pred_is_call,
    input  logic           pred_is_ret,
    input  rap_pkg::pc38_t pred_link_pc38,
    input  logic           flush_valid,

    output logic           accept,
    output logic           busy
);
    import rap_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // --------------------------------------------------
    // FSM
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ST_RUN;
        end
        else begin
            state <= next_state;
        end
    end

    // restore is a single cycle, a second flush must wait for busy to drop
    always_comb begin
        next_state = state;
        case (state)
            ST_RUN: begin
                if (flush_valid) begin
                    next_state = ST_RESTORE;
                end
            end
            ST_RESTORE: begin
                next_state = ST_RUN;
            end
            default: begin
                next_state = ST_RUN;
            end
        endcase
    end

    // --------------------------------------------------
    // outputs
    assign busy   = flush_valid || (state == ST_RESTORE);
    assign accept = pred_valid && !busy;

    assign rif.link_valid = accept && pred_is_call;
    assign rif.link_pc38  = pred_link_pc38;

    // nothing to pop on an empty stack, a call+return then is a plain push
    assign rif.ret_valid    = accept && pred_is_ret && !rif.ret_fallback;
    assign rif.update_valid = (state == ST_RESTORE);

endmodule

//--- ckpt_tag_counter.sv
`timescale 1ns/1ps

module ckpt_tag_counter (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               advance,
    input  logic               rewind,
    input  rap_pkg::ckpt_tag_t rewind_tag,
    output rap_pkg::ckpt_tag_t tag
);
    import rap_pkg::*;

    ckpt_tag_t next_tag;

    // flush restarts just past the flushed prediction
    always_comb begin
        next_tag = tag;
        if (rewind) begin
            next_tag = rewind_tag + 1'b1;
        end
        else if (advance) begin
            next_tag = tag + 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            tag <= '0;
        end
        else begin
            tag <= next_tag;
        end
    end

endmodule

//--- ckpt_table.sv
`timescale 1ns/1ps
`include "rap_cfg.svh"

module ckpt_table (
    input  logic               CLK,
    input  logic               nRST,
    ras_if.snap                rif,
    input  logic               snap_en,
    input  rap_pkg::ckpt_tag_t snap_tag,
    input  logic               restore_en,
    input  rap_pkg::ckpt_tag_t restore_tag
);
    import rap_pkg::*;

    // one snapshot word is {pointer, count}
    logic [$bits(ras_idx_t)+$bits(ras_cnt_t)-1:0] snap_wdata;
    logic [$bits(ras_idx_t)+$bits(ras_cnt_t)-1:0] snap_rdata;

    assign snap_wdata = {rif.ret_ras_idx, rif.ret_ras_cnt};

    distram_1rport_1wport #(
        .INNER_WIDTH ($bits(snap_wdata)),
        .OUTER_WIDTH (`RAP_CKPT_ENTRIES)
    ) u_snap_mem (
        .CLK    (CLK),
        .rindex (restore_tag),
        .rdata  (snap_rdata),
        .wen    (snap_en),
        .windex (snap_tag),
        .wdata  (snap_wdata)
    );

    // --------------------------------------------------
    // registered read-out, held until the next flush
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rif.update_ras_index <= '0;
            rif.update_ras_count <= '0;
        end
        else if (restore_en) begin
            {rif.update_ras_index, rif.update_ras_count} <= snap_rdata;
        end
    end

endmodule

//--- ras.sv
`timescale 1ns/1ps
`include "rap_cfg.svh"

module ras (
    input  logic CLK,
    input  logic nRST,
    ras_if.stack rif
);
    import rap_pkg::*;

    // --------------------------------------------------
    // storage port signals
    ras_idx_t rd_index;
    pc38_t    rd_data;
    logic     wr_en;
    ras_idx_t wr_index;
    pc38_t    wr_data;

    // pointer and count
    ras_idx_t sp;
    ras_idx_t next_sp;
    ras_idx_t sp_plus_1;
    ras_idx_t sp_minus_1;
    ras_cnt_t count;
    ras_cnt_t next_count;
    ras_cnt_t count_plus_1;
    ras_cnt_t count_minus_1;
    logic     empty;

    // --------------------------------------------------
    // state registers
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sp    <= '0;
            count <= '0;
        end
        else begin
            sp    <= next_sp;
            count <= next_count;
        end
    end

    always_comb begin
        sp_plus_1  = sp + 1'b1;
        sp_minus_1 = sp - 1'b1;

        // count sticks at full, oldest entry is overwritten by the wrap
        if (count == ras_cnt_t'(`RAP_RAS_ENTRIES)) begin
            count_plus_1 = count;
        end
        else begin
            count_plus_1 = count + 1'b1;
        end
        count_minus_1 = count - 1'b1;
    end

    assign empty = (count == '0);

    // --------------------------------------------------
    // next pointer, count and write
    always_comb begin
        next_sp    = sp;
        next_count = count;
        wr_en      = 1'b0;
        wr_index   = sp;
        wr_data    = rif.link_pc38;

        if (rif.update_valid) begin
            // restore from a checkpoint wins over everything
            next_sp    = rif.update_ras_index;
            next_count = rif.update_ras_count;
        end
        else if (rif.link_valid && rif.ret_valid && !empty) begin
            // replace the top in place
            wr_en = 1'b1;
        end
        else if (rif.link_valid) begin
            // plain push, also the call+return case on an empty stack
            wr_en      = 1'b1;
            wr_index   = sp_plus_1;
            next_sp    = sp_plus_1;
            next_count = count_plus_1;
        end
        else if (rif.ret_valid && !empty) begin
            next_sp    = sp_minus_1;
            next_count = count_minus_1;
        end
    end

    // --------------------------------------------------
    // top of stack
    assign rd_index         = sp;
    assign rif.ret_pc38     = rd_data;
    assign rif.ret_fallback = empty;
    assign rif.ret_ras_idx  = sp;
    assign rif.ret_ras_cnt  = count;

    distram_1rport_1wport #(
        .INNER_WIDTH ($bits(pc38_t)),
        .OUTER_WIDTH (`RAP_RAS_ENTRIES)
    ) u_stack_mem (
        .CLK    (CLK),
        .rindex (rd_index),
        .rdata  (rd_data),
        .wen    (wr_en),
        .windex (wr_index),
        .wdata  (wr_data)
    );

endmodule

//--- distram_1rport_1wport.sv
`timescale 1ns/1ps

module distram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 8
) (
    input  logic                           CLK,

    // asynchronous read
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // synchronous write
    input  logic                           wen,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

    // read sees the old word during a write to the same index
    assign rdata = mem[rindex];

endmodule

//--- ras_if.sv
`timescale 1ns/1ps

interface ras_if;
    import rap_pkg::*;

    // push side
    logic     link_valid;
    pc38_t    link_pc38;

    // pop side and current stack state
    logic     ret_valid;
    logic     ret_fallback;
    pc38_t    ret_pc38;
    ras_idx_t ret_ras_idx;
    ras_cnt_t ret_ras_cnt;

    // pointer and count restore
    logic     update_valid;
    ras_idx_t update_ras_index;
    ras_cnt_t update_ras_count;

    // operation strobes come from the controller
    modport ctrl (
        output link_valid, link_pc38, ret_valid, update_valid,
        input  ret_fallback
    );

    modport stack (
        input  link_valid, link_pc38, ret_valid,
        input  update_valid, update_ras_index, update_ras_count,
        output ret_fallback, ret_pc38, ret_ras_idx, ret_ras_cnt
    );

    // checkpoint table samples the state and drives the restore values
    modport snap (
        input  ret_ras_idx, ret_ras_cnt,
        output update_ras_index, update_ras_count
    );

endinterface

//--- rap_pkg.sv
`include "rap_cfg.svh"

package rap_pkg;

    // --------------------------------------------------
    // address and stack state

    // return address as held in the stack
    typedef logic [`RAP_PC_WIDTH-1:0] pc38_t;

    // stack pointer, wraps around the stack
    typedef logic [$clog2(`RAP_RAS_ENTRIES)-1:0] ras_idx_t;

    // valid entry count, one bit wider so it can reach full
    typedef logic [$clog2(`RAP_RAS_ENTRIES):0] ras_cnt_t;

    // checkpoint tag
    typedef logic [$clog2(`RAP_CKPT_ENTRIES)-1:0] ckpt_tag_t;

    // --------------------------------------------------
    // controller
    typedef enum logic {ST_RUN, ST_RESTORE} ctrl_state_t;

endpackage

//--- rap_cfg.svh
`ifndef RAP_CFG_SVH
`define RAP_CFG_SVH

// stack depth, power of two
`define RAP_RAS_ENTRIES 8

// checkpoint tags in flight, power of two
`define RAP_CKPT_ENTRIES 4

// stored return address width
`define RAP_PC_WIDTH 38

`endif
